//--- flist.f
+incdir+include
logic/membus_data_pkg.sv
logic/membus_ctrl_pkg.sv
logic/cen_gen.sv
logic/access_seq.sv
logic/mem_ctrl.sv
logic/membus_top.sv
test/membus_sva.sv
test/membus_tb.sv

//--- test/membus_tb.sv
// directed testbench for the memory-access unit, with a 64 KiB byte memory model
// each test runs four-phase req/ack accesses and checks results against a reference copy
`timescale 1ns/1ns
`include "membus_defines.svh"

module membus_tb
    import membus_data_pkg::*;
    import membus_ctrl_pkg::*;
();

    localparam int N_ACCESS = 16 + 8 + 12 + 4 + 12;         // accesses over all five tests
    localparam int LIMIT    = N_ACCESS * 32 * `CEN2_DIV + 32; // 64 clk per access at div 2

    logic        clk;
    logic        rst;
    logic        halt;
    logic        req;
    acc_cmd_t    cmd;
    addr_src_t   src;
    logic [ 3:0] intvec;
    logic        ack;
    logic [15:0] pc;
    logic [15:0] idx_addr;
    logic        idx_adv;
    logic [15:0] psh_addr;
    logic [15:0] regs_x;
    logic [15:0] regs_y;
    logic [15:0] wdata;
    fetch_word_t rdata;
    logic [ 7:0] op;
    logic        is_op;
    logic        up_pc;
    logic [15:0] mem_addr;
    logic [ 7:0] mem_dout;
    logic        mem_we;
    logic [ 7:0] mem_din;

    logic [7:0] mem     [0:65535];  // bus-side memory
    logic [7:0] ref_mem [0:65535];  // expected contents, updated by the tests

    fetch_word_t res_word;          // results captured at ack
    logic [7:0]  res_op;
    logic        res_is_op;
    logic        saw_up_pc;
    logic        access_done;       // stops the halt driver

    int          cycles = 0;
    int          errors;
    int          failed_tests;
    int          test_err_base;
    int          sva_errs;
    string       cur_test;

    membus_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign mem_din = mem[mem_addr];  // asynchronous read

    always @(posedge clk) begin
        if (mem_we) mem[mem_addr] <= mem_dout;
    end

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: run did not end within %0d clk cycles", LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("Mismatch in %s, %s: expected %h, got %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = errors;
    endtask

    task automatic end_test(input int n_acc);
        if (errors == test_err_base) begin
            $display("%s: ok, %0d accesses", cur_test, n_acc);
        end else begin
            $display("%s: failed with %0d errors", cur_test, errors - test_err_base);
            failed_tests++;
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[a]     = 8'($urandom);
            ref_mem[a] = mem[a];
        end
    endtask

    // one four-phase access, unused sources get noise
    task automatic do_access(input acc_cmd_t c, input addr_src_t s, input logic [15:0] addr,
                             input logic adv, input logic [15:0] data, input logic [3:0] vsel);
        @(posedge clk);
        #1;
        pc       = 16'($urandom);
        idx_addr = 16'($urandom);
        psh_addr = 16'($urandom);
        regs_x   = 16'($urandom);
        regs_y   = 16'($urandom);
        case (s)
            SRC_PC:  pc       = addr;
            SRC_IDX: idx_addr = addr;
            SRC_PSH: psh_addr = addr;
            SRC_X:   regs_x   = addr;
            default: regs_y   = addr;
        endcase
        idx_adv   = adv;
        cmd       = c;
        src       = s;
        wdata     = data;
        intvec    = vsel;
        req       = 1'b1;
        saw_up_pc = 1'b0;
        do begin
            @(posedge clk);
            #1;
            if (up_pc) saw_up_pc = 1'b1;    // must show up before ack
        end while (!ack);
        res_word  = rdata;
        res_op    = op;
        res_is_op = is_op;
        req       = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    task automatic fetch_and_operand_reads();
        addr_src_t   rd_srcs [3];
        logic [15:0] a;
        rd_srcs = '{SRC_X, SRC_Y, SRC_PSH};
        start_test("fetch_and_operand_reads");
        for (int i = 0; i < 4; i++) begin
            a = 16'($urandom);
            do_access(CMD_FETCH_OP, SRC_PC, a, 1'b0, 16'h0000, 4'b0000);
            if (res_op !== ref_mem[a]) report_mismatch("op", {8'h00, ref_mem[a]}, {8'h00, res_op});
            if (res_is_op !== 1'b1) report_mismatch("is_op", 16'h0001, {15'd0, res_is_op});
            foreach (rd_srcs[k]) begin
                a = 16'($urandom);
                do_access(CMD_RD8, rd_srcs[k], a, 1'b0, 16'h0000, 4'b0000);
                if (res_word.word[7:0] !== ref_mem[a])
                    report_mismatch("byte", {8'h00, ref_mem[a]}, {8'h00, res_word.word[7:0]});
                if (res_is_op !== 1'b0) report_mismatch("is_op", 16'h0000, {15'd0, res_is_op});
            end
        end
        end_test(16);
    endtask

    task automatic indexed_word_read();
        logic [15:0] base;
        logic [15:0] a;
        logic [15:0] a1;
        logic        adv;
        start_test("indexed_word_read");
        for (int i = 0; i < 8; i++) begin
            base = 16'($urandom);
            adv  = 1'($urandom);
            a    = base + {15'd0, adv};    // effective index address
            a1   = a + 16'd1;
            do_access(CMD_RD16, SRC_IDX, base, adv, 16'h0000, 4'b0000);
            if (res_word.word !== {ref_mem[a], ref_mem[a1]})
                report_mismatch("word", {ref_mem[a], ref_mem[a1]}, res_word.word);
            if (res_word.pair.op !== ref_mem[a])
                report_mismatch("op view", {8'h00, ref_mem[a]}, {8'h00, res_word.pair.op});
            if (res_word.pair.post !== ref_mem[a1])
                report_mismatch("post view", {8'h00, ref_mem[a1]}, {8'h00, res_word.pair.post});
        end
        end_test(8);
    endtask

    task automatic write_and_readback();
        logic [15:0] a;
        logic [15:0] a1;
        logic [15:0] d;
        start_test("write_and_readback");
        for (int i = 0; i < 4; i++) begin
            a = 16'($urandom);
            d = 16'($urandom);
            do_access(CMD_WR8, SRC_X, a, 1'b0, d, 4'b0000);
            ref_mem[a] = d[7:0];   // only the low byte lands
            if (mem[a] !== ref_mem[a])
                report_mismatch("wr8 byte", {8'h00, ref_mem[a]}, {8'h00, mem[a]});
            a  = 16'($urandom);
            a1 = a + 16'd1;
            d  = 16'($urandom);
            do_access(CMD_WR16, SRC_Y, a, 1'b0, d, 4'b0000);
            ref_mem[a]  = d[15:8];  // big-endian
            ref_mem[a1] = d[7:0];
            if ({mem[a], mem[a1]} !== {ref_mem[a], ref_mem[a1]})
                report_mismatch("wr16 bytes", {ref_mem[a], ref_mem[a1]}, {mem[a], mem[a1]});
            do_access(CMD_RD16, SRC_Y, a, 1'b0, 16'h0000, 4'b0000);
            if (res_word.word !== d) report_mismatch("readback", d, res_word.word);
        end
        end_test(12);
    endtask

    task automatic vector_fetches();
        logic [15:0] vec_tab [4];
        logic [15:0] v;
        logic [15:0] v1;
        vec_tab = '{`VEC_IRQ, `VEC_FIRQ, `VEC_NMI, `VEC_RST};   // by intvec bit
        start_test("vector_fetches");
        for (int i = 0; i < 4; i++) begin
            v  = vec_tab[i];
            v1 = v + 16'd1;
            do_access(CMD_VECTOR, SRC_PC, 16'($urandom), 1'b0, 16'h0000, 4'(1 << i));
            if (res_word.word !== {ref_mem[v], ref_mem[v1]})
                report_mismatch("vector", {ref_mem[v], ref_mem[v1]}, res_word.word);
            if (!saw_up_pc) report_failure("up_pc was not seen high before ack");
        end
        end_test(4);
    endtask

    // random halt stretches until the running access is through
    task automatic toggle_halt();
        int left;
        left = 0;
        while (!access_done) begin
            @(posedge clk);
            #1;
            if (left > 0) begin
                left--;
            end else begin
                halt = ~halt;
                left = halt ? 1 + $urandom % 4 : 2 + $urandom % 5;
            end
        end
        halt = 1'b0;
    endtask

    task automatic compare_memory();
        int diffs;
        diffs = 0;
        for (int a = 0; a < 65536; a++) begin
            if (mem[a] !== ref_mem[a]) begin
                if (diffs < 4) report_mismatch($sformatf("memory at %h", a[15:0]),
                                               {8'h00, ref_mem[a]}, {8'h00, mem[a]});
                diffs++;
            end
        end
        if (diffs > 0) report_failure($sformatf("%0d bytes differ from the reference", diffs));
    endtask

    task automatic halt_stretches();
        logic [15:0] a;
        logic [15:0] a1;
        logic [15:0] d;
        int          kind;
        acc_cmd_t    c;
        addr_src_t   s;
        start_test("halt_stretches");
        for (int i = 0; i < 12; i++) begin
            kind = $urandom % 4;
            a    = 16'($urandom);
            a1   = a + 16'd1;
            d    = 16'($urandom);
            case (kind)
                0:       begin c = CMD_RD8;  s = SRC_PSH; end
                1:       begin c = CMD_RD16; s = SRC_IDX; end
                2:       begin c = CMD_WR8;  s = SRC_X;   end
                default: begin c = CMD_WR16; s = SRC_Y;   end
            endcase
            access_done = 1'b0;
            fork
                begin
                    do_access(c, s, a, 1'b0, d, 4'b0000);
                    access_done = 1'b1;
                end
                toggle_halt();
            join
            case (kind)
                0: if (res_word.word[7:0] !== ref_mem[a])
                    report_mismatch("byte", {8'h00, ref_mem[a]}, {8'h00, res_word.word[7:0]});
                1: if (res_word.word !== {ref_mem[a], ref_mem[a1]})
                    report_mismatch("word", {ref_mem[a], ref_mem[a1]}, res_word.word);
                2: ref_mem[a] = d[7:0];
                default: begin
                    ref_mem[a]  = d[15:8];
                    ref_mem[a1] = d[7:0];
                end
            endcase
        end
        compare_memory();  // whole memory against the write-only model
        end_test(12);
    endtask

    initial begin
        void'($urandom(32'ha09b));
        rst          = 1'b1;
        halt         = 1'b0;
        req          = 1'b0;
        cmd          = CMD_FETCH_OP;
        src          = SRC_PC;
        intvec       = 4'b0000;
        pc           = 16'h0000;
        idx_addr     = 16'h0000;
        idx_adv      = 1'b0;
        psh_addr     = 16'h0000;
        regs_x       = 16'h0000;
        regs_y       = 16'h0000;
        wdata        = 16'h0000;
        access_done  = 1'b0;
        errors       = 0;
        failed_tests = 0;
        fill_memory();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        fetch_and_operand_reads();
        indexed_word_read();
        write_and_readback();
        vector_fetches();
        halt_stretches();

        sva_errs = dut.u_seq.seq_chk.err_cnt + dut.u_ctrl.ctrl_chk.err_cnt;
        $display("summary: 5 tests, %0d failed, %0d check errors, %0d assertion failures",
                 failed_tests, errors, sva_errs);
        if (errors == 0 && sva_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/membus_sva.sv
// concurrent checks on the host handshake and the byte-wide memory bus
// bound into access_seq and mem_ctrl, each binding ties off the signals its target lacks
`timescale 1ns/1ns

module membus_sva (
    input logic        clk,
    input logic        rst,
    input logic        cen2,
    input logic        halt,
    input logic        req,
    input logic        ack,
    input logic        mem_we,
    input logic [15:0] mem_addr
);

    int err_cnt = 0;    // failures seen by this instance, summed up by the testbench

    // ack only ever rises into a live request, req is looked at on the edge that set ack
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            err_cnt++;
            $error("ack rose while req was low");
        end

    // a byte is written only on an enable tick, and for a single clk
    we_on_cen2: assert property (@(posedge clk) disable iff (rst) mem_we |-> cen2 ##1 !mem_we)
        else begin
            err_cnt++;
            $error("mem_we high outside a cen2 tick or for more than one clk");
        end

    // halt freezes the address, so the value after a halted edge is unchanged
    addr_holds: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(mem_addr))
        else begin
            err_cnt++;
            $error("mem_addr moved while halt was high");
        end

endmodule

// sequencer side, handshake only
bind access_seq membus_sva seq_chk (
    .clk (clk), .rst (rst), .cen2 (cen2), .halt (halt), .req (req), .ack (ack),
    .mem_we (1'b0), .mem_addr (16'h0000)
);

// controller side, memory bus only
bind mem_ctrl membus_sva ctrl_chk (
    .clk (clk), .rst (rst), .cen2 (cen2), .halt (halt), .req (1'b0), .ack (1'b0),
    .mem_we (mem_we), .mem_addr (mem_addr)
);

//--- logic/membus_top.sv
// top of the memory-access unit
// wires the enable generator, the access sequencer and the memory controller
`timescale 1ns/1ns

module membus_top
    import membus_data_pkg::*;
    import membus_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        halt,
    // host handshake
    input  logic        req,
    input  acc_cmd_t    cmd,
    input  addr_src_t   src,
    input  logic [ 3:0] intvec,
    output logic        ack,
    // address sources and write data
    input  logic [15:0] pc,
    input  logic [15:0] idx_addr,
    input  logic        idx_adv,
    input  logic [15:0] psh_addr,
    input  logic [15:0] regs_x,
    input  logic [15:0] regs_y,
    input  logic [15:0] wdata,
    // results
    output fetch_word_t rdata,
    output logic [ 7:0] op,
    output logic        is_op,
    output logic        up_pc,
    // memory bus
    output logic [15:0] mem_addr,
    output logic [ 7:0] mem_dout,
    output logic        mem_we,
    input  logic [ 7:0] mem_din
);

    logic cen2;
    logic cen;
    logic go;
    logic wide;
    logic wr;
    logic vec;
    logic opfetch;
    logic busy;

    cen_gen u_cen (
        .clk  (clk),
        .rst  (rst),
        .cen2 (cen2),
        .cen  (cen)
    );

    access_seq u_seq (
        .clk (clk), .rst (rst), .cen2 (cen2), .halt (halt),
        .req (req), .cmd (cmd), .busy (busy), .ack (ack),
        .go (go), .wide (wide), .wr (wr), .vec (vec), .opfetch (opfetch)
    );

    mem_ctrl u_ctrl (
        .clk (clk), .rst (rst), .cen2 (cen2), .cen (cen), .halt (halt),
        .go (go), .wide (wide), .wr (wr), .vec (vec), .opfetch (opfetch),
        .src (src), .intvec (intvec), .pc (pc),
        .idx_addr (idx_addr), .idx_adv (idx_adv), .psh_addr (psh_addr),
        .regs_x (regs_x), .regs_y (regs_y), .wdata (wdata), .mem_din (mem_din),
        .mem_addr (mem_addr), .mem_dout (mem_dout), .mem_we (mem_we),
        .busy (busy), .rdata (rdata), .op (op), .is_op (is_op), .up_pc (up_pc)
    );

endmodule

//--- logic/mem_ctrl.sv
// memory controller, picks the address and moves bytes over the 8-bit bus
// word transfers go high byte first at the lower address
`timescale 1ns/1ns
`include "membus_defines.svh"

module mem_ctrl
    import membus_data_pkg::*;
    import membus_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen2,
    input  logic        cen,
    input  logic        halt,
    input  logic        go,
    input  logic        wide,
    input  logic        wr,
    input  logic        vec,
    input  logic        opfetch,
    input  addr_src_t   src,
    input  logic [ 3:0] intvec,     // one-hot vector select
    input  logic [15:0] pc,
    input  logic [15:0] idx_addr,
    input  logic        idx_adv,
    input  logic [15:0] psh_addr,
    input  logic [15:0] regs_x,
    input  logic [15:0] regs_y,
    input  logic [15:0] wdata,
    input  logic [ 7:0] mem_din,
    output logic [15:0] mem_addr,
    output logic [ 7:0] mem_dout,
    output logic        mem_we,
    output logic        busy,
    output fetch_word_t rdata,
    output logic [ 7:0] op,
    output logic        is_op,
    output logic        up_pc       // vector word is ready for the pc
);

    logic [15:0] src_addr;
    logic [15:0] vec_addr;
    logic        second;    // working on the low byte of a word
    logic        tick;
    logic        wr_step;   // a byte goes out this tick
    logic        rd_hi;
    logic        rd_lo;
    logic        rd_byte;

    assign tick    = cen2 && !halt;
    assign wr_step = busy && wr && cen;     // writes only line up with cen
    assign rd_hi   = busy && !wr && wide && !second;
    assign rd_lo   = busy && !wr && wide && second;
    assign rd_byte = busy && !wr && !wide;
    assign mem_we  = tick && wr_step;       // one clk per written byte

    // address source mux
    always_comb begin
        case (src)
            SRC_PC:  src_addr = pc;
            SRC_IDX: src_addr = idx_addr + {15'd0, idx_adv};
            SRC_PSH: src_addr = psh_addr;
            SRC_X:   src_addr = regs_x;
            SRC_Y:   src_addr = regs_y;
            default: src_addr = pc;
        endcase
    end

    always_comb begin
        case (intvec)
            4'b0001: vec_addr = `VEC_IRQ;
            4'b0010: vec_addr = `VEC_FIRQ;
            4'b0100: vec_addr = `VEC_NMI;
            default: vec_addr = `VEC_RST;   // 4'b1000 and anything odd
        endcase
    end

    // address and transfer control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_addr <= '0;
            busy     <= 1'b0;
            second   <= 1'b0;
            is_op    <= 1'b0;
            up_pc    <= 1'b0;
        end else if (tick) begin
            up_pc <= 1'b0;
            if (go) begin
                mem_addr <= vec ? vec_addr : src_addr;
                busy     <= 1'b1;
                second   <= 1'b0;
                is_op    <= 1'b0;
            end else if (wr_step || rd_hi) begin
                if (wide && !second) begin
                    mem_addr <= mem_addr + 16'd1;   // on to the low byte
                    second   <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end else if (rd_lo) begin
                busy  <= 1'b0;
                up_pc <= vec;   // vector word complete
            end else if (rd_byte) begin
                busy  <= 1'b0;
                is_op <= opfetch;
            end
        end
    end

    // data path, write bytes out and capture read bytes
    always_ff @(posedge clk) begin
        if (tick) begin
            if (go) begin
                mem_dout <= wide ? wdata[15:8] : wdata[7:0];
            end else if (wr_step && wide && !second) begin
                mem_dout <= wdata[7:0];     // low byte follows
            end
            if (rd_hi) rdata.pair.op <= mem_din;    // high byte first
            if (rd_lo) rdata.pair.post <= mem_din;
            if (rd_byte) begin
                rdata.word <= {8'h00, mem_din};
                if (opfetch) op <= mem_din;
            end
        end
    end

endmodule

//--- logic/access_seq.sv
// access sequencer, serves one host request at a time over req/ack
// decodes the command into controller mode lines and waits for the transfer to end
`timescale 1ns/1ns

module access_seq
    import membus_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen2,
    input  logic     halt,      // freezes the whole sequencer
    input  logic     req,       // four-phase request from host
    input  acc_cmd_t cmd,
    input  logic     busy,      // controller still moving bytes
    output logic     ack,
    output logic     go,        // one-tick start to the controller
    output logic     wide,      // 16-bit transfer
    output logic     wr,
    output logic     vec,
    output logic     opfetch
);

    seq_state_t state;

    logic dec_wide;
    logic dec_wr;
    logic dec_vec;
    logic dec_opfetch;
    logic tick;

    assign tick = cen2 && !halt;  // one step of work

    // command to mode line decode
    always_comb begin
        dec_wide    = 1'b0;
        dec_wr      = 1'b0;
        dec_vec     = 1'b0;
        dec_opfetch = 1'b0;
        case (cmd)
            CMD_FETCH_OP: dec_opfetch = 1'b1;
            CMD_RD8:      ;                     // plain byte read
            CMD_RD16:     dec_wide = 1'b1;
            CMD_WR8:      dec_wr   = 1'b1;
            CMD_WR16: begin
                dec_wide = 1'b1;
                dec_wr   = 1'b1;
            end
            CMD_VECTOR: begin
                dec_wide = 1'b1;    // vectors are words
                dec_vec  = 1'b1;
            end
            default:      ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            ack     <= 1'b0;
            go      <= 1'b0;
            wide    <= 1'b0;
            wr      <= 1'b0;
            vec     <= 1'b0;
            opfetch <= 1'b0;
        end else if (tick) begin
            go <= 1'b0;     // go is high for a single tick only
            case (state)
                IDLE: if (req) begin
                    // mode lines stay put for the whole access
                    wide    <= dec_wide;
                    wr      <= dec_wr;
                    vec     <= dec_vec;
                    opfetch <= dec_opfetch;
                    go      <= 1'b1;
                    state   <= ISSUE;
                end
                ISSUE: state <= WAIT;   // controller loads the address now
                WAIT: if (!busy) begin
                    ack   <= 1'b1;      // last byte is in, data valid
                    state <= DONE;
                end
                DONE: if (!req) begin
                    ack   <= 1'b0;      // close the handshake
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/cen_gen.sv
// clock-enable generator for the memory-access unit
// cen2 pulses once every CEN2_DIV clk cycles, cen on every second cen2
`timescale 1ns/1ns
`include "membus_defines.svh"

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen2,
    output logic cen
);

    localparam int CW = (`CEN2_DIV > 1) ? $clog2(`CEN2_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(`CEN2_DIV - 1);

    logic [CW-1:0] cnt;     // divide counter
    logic          tog;     // flips on each cen2, picks every other one

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tog  <= 1'b0;
            cen2 <= 1'b0;
            cen  <= 1'b0;
        end else if (cnt == LAST) begin
            cnt  <= '0;
            cen2 <= 1'b1;
            cen  <= tog;    // half rate, aligned with cen2
            tog  <= ~tog;
        end else begin
            cnt  <= cnt + 1'b1;
            cen2 <= 1'b0;
            cen  <= 1'b0;
        end
    end

endmodule

//--- logic/membus_ctrl_pkg.sv
// control types shared by the sequencer, the memory controller and the host side
// import where commands, address sources or sequencer states are handled
`include "membus_defines.svh"

package membus_ctrl_pkg;

    // access request from the host
    typedef enum logic [`CMD_W-1:0] {
        CMD_FETCH_OP = `CMD_CODE_FETCH_OP,  // opcode byte at pc
        CMD_RD8      = `CMD_CODE_RD8,       // operand byte
        CMD_RD16     = `CMD_CODE_RD16,
        CMD_WR8      = `CMD_CODE_WR8,
        CMD_WR16     = `CMD_CODE_WR16,
        CMD_VECTOR   = `CMD_CODE_VECTOR     // interrupt vector word
    } acc_cmd_t;

    // where the access address comes from
    typedef enum logic [2:0] {
        SRC_PC,
        SRC_IDX,    // idx_addr plus idx_adv
        SRC_PSH,    // stack
        SRC_X,
        SRC_Y
    } addr_src_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        DONE
    } seq_state_t;

endpackage

//--- logic/membus_data_pkg.sv
// data types for words moved over the byte-wide memory bus
// import into any module that handles fetched data
package membus_data_pkg;

    // opcode byte and its postbyte as laid out in memory
    // op sits at the lower address, so it lands in the high byte
    typedef struct packed {
        logic [7:0] op;     // first byte fetched
        logic [7:0] post;   // second byte fetched
    } op_pair_t;

    // one fetched word, read either as a plain value or as a byte pair
    typedef union packed {
        logic [15:0] word;  // big-endian 16-bit value
        op_pair_t    pair;  // opcode and postbyte view
    } fetch_word_t;

endpackage

//--- include/membus_defines.svh
// shared constants for the memory-access unit
// include wherever vector addresses, enable pacing or command codes are needed
`ifndef MEMBUS_DEFINES_SVH
`define MEMBUS_DEFINES_SVH

// interrupt vector addresses, each holds a big-endian word
`define VEC_IRQ  16'hFFF8   // intvec bit 0
`define VEC_FIRQ 16'hFFF6   // intvec bit 1
`define VEC_NMI  16'hFFFC   // intvec bit 2
`define VEC_RST  16'hFFFE   // intvec bit 3

// clk cycles per cen2 pulse, cen runs at half of that
`define CEN2_DIV 2

// access command encoding
`define CMD_W            3
`define CMD_CODE_FETCH_OP 3'd0  // opcode at pc
`define CMD_CODE_RD8      3'd1
`define CMD_CODE_RD16     3'd2
`define CMD_CODE_WR8      3'd3
`define CMD_CODE_WR16     3'd4
`define CMD_CODE_VECTOR   3'd5

`endif
